//--- logic/audio_pkg.sv
`default_nettype none

package audio_pkg;

  //////////////////////////////
  // ac97 frame layout
  //////////////////////////////

  localparam int FRAME_BITS = 256;   // bit clocks per frame, 48 kHz frame rate
  localparam int SYNC_BITS  = 16;    // synch high across the tag slot
  localparam int SLOT_BITS  = 20;    // slots 1..4

  // first bit count of each slot
  localparam int SLOT1_START = 16;   // command address
  localparam int SLOT2_START = 36;   // command data
  localparam int SLOT3_START = 56;   // left pcm
  localparam int SLOT4_START = 76;   // right pcm

  //////////////////////////////
  // audio and volume
  //////////////////////////////

  localparam int SAMPLE_BITS  = 8;   // top bits of a 20 bit pcm slot
  localparam int VOLUME_BITS  = 5;
  localparam int VOLUME_RESET = 8;
  localparam int VOLUME_MAX   = 31;  // also full attenuation

  // 10 ms at 12.288 MHz
  localparam int DEBOUNCE_CYCLES     = 122880;
  localparam int DEBOUNCE_COUNT_BITS = $clog2(DEBOUNCE_CYCLES + 1);

  // codec held in reset this long before frames start
  localparam int CODEC_RESET_CYCLES = 1023;
  localparam int RESET_COUNT_BITS   = $clog2(CODEC_RESET_CYCLES + 1);

  //////////////////////////////
  // sample memory and commands
  //////////////////////////////

  localparam int STORE_ADDR_BITS = 10;
  localparam int STORE_DEPTH     = 1 << STORE_ADDR_BITS;  // 1024 samples, ~21 ms

  localparam int CMD_ADDR_BITS = 8;
  localparam int CMD_DATA_BITS = 16;

  typedef logic [SAMPLE_BITS-1:0] sample_t;

  // one codec register access, sent in slots 1 and 2
  typedef struct packed {
    logic                     valid;    // drives both command tag bits
    logic [CMD_ADDR_BITS-1:0] address;  // bit 7 set means read
    logic [CMD_DATA_BITS-1:0] data;
  } codec_command_t;

endpackage

`default_nettype wire

//--- logic/button_debounce.sv
`default_nettype none
`timescale 1ns/1ns

module button_debounce (
  input  wire  clock,
  input  wire  reset,
  input  wire  noisy,
  output logic clean
);

  logic [audio_pkg::DEBOUNCE_COUNT_BITS-1:0] count;  // cycles since last change
  logic last;                                        // previous raw sample

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      last  <= noisy;
      clean <= noisy;  // start out agreeing with the pin
    end else if (noisy != last) begin
      // input moved, start the wait over
      last  <= noisy;
      count <= '0;
    end else if (count == audio_pkg::DEBOUNCE_COUNT_BITS'(audio_pkg::DEBOUNCE_CYCLES)) begin
      clean <= last;  // stable long enough
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/volume_control.sv
`default_nettype none
`timescale 1ns/1ns

module volume_control (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                button_up,    // active high
  input  wire                                button_down,  // active high
  output logic [audio_pkg::VOLUME_BITS-1:0]  volume
);

  logic up_clean, down_clean;  // debounced levels
  logic up_q, down_q;          // one cycle old, for edges
  logic up_press, down_press;

  button_debounce up_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_up),
    .clean (up_clean)
  );

  button_debounce down_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_down),
    .clean (down_clean)
  );

  assign up_press   = up_clean & ~up_q;
  assign down_press = down_clean & ~down_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      volume <= audio_pkg::VOLUME_BITS'(audio_pkg::VOLUME_RESET);
      up_q   <= 1'b1;  // a button held through reset is no press
      down_q <= 1'b1;
    end else begin
      up_q   <= up_clean;
      down_q <= down_clean;
      // both at once cancel out
      if (up_press && !down_press &&
          volume != audio_pkg::VOLUME_BITS'(audio_pkg::VOLUME_MAX))
        volume <= volume + 1'b1;
      else if (down_press && !up_press && volume != '0)
        volume <= volume - 1'b1;  // floor at 0
    end
  end

endmodule

`default_nettype wire

//--- logic/codec_command_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

module codec_command_sequencer (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                frame_strobe,  // one per frame
  input  wire [audio_pkg::VOLUME_BITS-1:0]   volume,
  output audio_pkg::codec_command_t          command
);

  logic [3:0] step;  // 16 step loop, one step per frame
  logic [audio_pkg::VOLUME_BITS-1:0] atten;
  logic [audio_pkg::CMD_ADDR_BITS-1:0] next_address;
  logic [audio_pkg::CMD_DATA_BITS-1:0] next_data;

  // codec registers count attenuation, not gain
  assign atten = audio_pkg::VOLUME_BITS'(audio_pkg::VOLUME_MAX) - volume;

  //////////////////////////////
  // step table
  //////////////////////////////

  always_comb begin
    next_address = 8'h80;  // read vendor id, harmless filler
    next_data    = 16'h0000;
    case (step)
      4'd3: begin  // headphone volume, left and right
        next_address = 8'h04;
        next_data    = {3'b000, atten, 3'b000, atten};
      end
      4'd5: begin
        next_address = 8'h18;  // pcm out volume
        next_data    = 16'h0808;
      end
      4'd6: begin
        next_address = 8'h1A;  // record select = mic both sides
        next_data    = 16'h0000;
      end
      4'd7: begin
        next_address = 8'h1C;  // record gain at max
        next_data    = 16'h0F0F;
      end
      4'd9: begin
        next_address = 8'h0E;  // mic volume with +20 dB boost
        next_data    = 16'h8048;
      end
      4'd10: begin
        next_address = 8'h0A;  // pc beep
        next_data    = 16'h0000;
      end
      4'd11: begin
        next_address = 8'h20;  // general purpose, pcm out path
        next_data    = 16'h8000;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step    <= '0;
      command <= '0;
    end else begin
      if (frame_strobe)
        step <= step + 1'b1;  // wraps after 15
      command <= '{valid: 1'b1, address: next_address, data: next_data};
    end
  end

endmodule

`default_nettype wire

//--- logic/ac97_frame_engine.sv
`default_nettype none
`timescale 1ns/1ns

module ac97_frame_engine (
  input  wire                        clock,          // codec bit clock
  input  wire                        reset,
  input  audio_pkg::codec_command_t  command,
  input  audio_pkg::sample_t         play_sample,
  output audio_pkg::sample_t         mic_sample,
  output logic                       frame_strobe,
  output logic                       codec_reset_b,
  output logic                       ac97_synch,
  output logic                       ac97_sdata_out,
  input  wire                        ac97_sdata_in
);

  logic [audio_pkg::RESET_COUNT_BITS-1:0] reset_count;
  logic [7:0] bit_count;  // position within the 256 bit frame

  audio_pkg::codec_command_t cmd_q;     // command for the current frame
  audio_pkg::sample_t        sample_q;  // pcm for the current frame

  logic [audio_pkg::SLOT_BITS-1:0] addr_word;    // slot 1 image
  logic [audio_pkg::SLOT_BITS-1:0] data_word;    // slot 2 image
  logic [audio_pkg::SLOT_BITS-1:0] sample_word;  // slots 3 and 4
  logic [audio_pkg::SLOT_BITS-1:0] rx_word;      // incoming left slot
  logic tx_bit;
  logic rx_window;

  // left-justified slot contents
  assign addr_word = {cmd_q.address,
                      {(audio_pkg::SLOT_BITS - audio_pkg::CMD_ADDR_BITS){1'b0}}};
  assign data_word = {cmd_q.data,
                      {(audio_pkg::SLOT_BITS - audio_pkg::CMD_DATA_BITS){1'b0}}};
  assign sample_word = {sample_q,
                        {(audio_pkg::SLOT_BITS - audio_pkg::SAMPLE_BITS){1'b0}}};

  // last bit of the frame, counter sits at 0 until release
  assign frame_strobe = codec_reset_b && (bit_count == 8'(audio_pkg::FRAME_BITS - 1));

  //////////////////////////////
  // outgoing bit select
  //////////////////////////////

  always_comb begin
    tx_bit = 1'b0;
    if (bit_count < 8'(audio_pkg::SYNC_BITS)) begin
      case (bit_count[3:0])  // slot 0 tags
        4'd0:       tx_bit = 1'b1;         // frame valid
        4'd1, 4'd2: tx_bit = cmd_q.valid;  // address and data tags
        4'd3, 4'd4: tx_bit = 1'b1;         // left and right pcm valid
        default:    tx_bit = 1'b0;
      endcase
    end else if (bit_count < 8'(audio_pkg::SLOT2_START)) begin
      tx_bit = cmd_q.valid &
               addr_word[5'(audio_pkg::SLOT2_START - 1 - int'(bit_count))];
    end else if (bit_count < 8'(audio_pkg::SLOT3_START)) begin
      tx_bit = cmd_q.valid &
               data_word[5'(audio_pkg::SLOT3_START - 1 - int'(bit_count))];
    end else if (bit_count < 8'(audio_pkg::SLOT4_START)) begin
      tx_bit = sample_word[5'(audio_pkg::SLOT4_START - 1 - int'(bit_count))];
    end else if (bit_count < 8'(audio_pkg::SLOT4_START + audio_pkg::SLOT_BITS)) begin
      // right copy of the same sample
      tx_bit = sample_word[5'(audio_pkg::SLOT4_START + audio_pkg::SLOT_BITS - 1
                              - int'(bit_count))];
    end
  end

  //////////////////////////////
  // reset delay, counter, synch
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      reset_count    <= '0;
      codec_reset_b  <= 1'b0;
      bit_count      <= '0;
      ac97_synch     <= 1'b0;
      ac97_sdata_out <= 1'b0;
      cmd_q          <= '0;  // first frame goes out empty
      sample_q       <= '0;
    end else if (!codec_reset_b) begin
      if (reset_count == audio_pkg::RESET_COUNT_BITS'(audio_pkg::CODEC_RESET_CYCLES)) begin
        codec_reset_b <= 1'b1;
        ac97_synch    <= 1'b1;  // frame 0 starts right away
      end else begin
        reset_count <= reset_count + 1'b1;
      end
    end else begin
      bit_count      <= bit_count + 1'b1;  // wraps at 256
      ac97_sdata_out <= tx_bit;
      if (bit_count == 8'(audio_pkg::FRAME_BITS - 1))
        ac97_synch <= 1'b1;
      else if (bit_count == 8'(audio_pkg::SYNC_BITS - 1))
        ac97_synch <= 1'b0;
      if (frame_strobe) begin
        cmd_q    <= command;  // picked up for the next frame
        sample_q <= play_sample;
      end
    end
  end

  //////////////////////////////
  // left slot receive
  //////////////////////////////

  // codec bits land one count after they leave, so 57..76
  assign rx_window = codec_reset_b &&
                     (bit_count >= 8'(audio_pkg::SLOT3_START + 1)) &&
                     (bit_count <= 8'(audio_pkg::SLOT4_START));

  always_ff @(posedge clock) begin
    if (rx_window)
      rx_word <= {rx_word[audio_pkg::SLOT_BITS-2:0], ac97_sdata_in};  // msb first
  end

  assign mic_sample = rx_word[audio_pkg::SLOT_BITS-1 -: audio_pkg::SAMPLE_BITS];

endmodule

`default_nettype wire

//--- logic/sample_store.sv
`default_nettype none
`timescale 1ns/1ns

module sample_store (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 frame_strobe,
  input  wire                 record,       // high records, low loops back
  input  audio_pkg::sample_t  mic_sample,
  output audio_pkg::sample_t  play_sample
);

  audio_pkg::sample_t mem [audio_pkg::STORE_DEPTH];  // block ram

  logic [audio_pkg::STORE_ADDR_BITS:0]   length;   // also the write pointer
  logic [audio_pkg::STORE_ADDR_BITS:0]   wr_addr;
  logic [audio_pkg::STORE_ADDR_BITS-1:0] rd_ptr;
  logic [audio_pkg::STORE_ADDR_BITS:0]   rd_next;
  logic record_q;
  logic record_rise;
  logic store_full;
  logic write_en;
  audio_pkg::sample_t rd_data;

  assign record_rise = record & ~record_q;
  assign wr_addr     = record_rise ? '0 : length;  // new take starts at 0
  assign store_full  = (wr_addr == (audio_pkg::STORE_ADDR_BITS + 1)'(audio_pkg::STORE_DEPTH));
  assign write_en    = record & frame_strobe & ~store_full;
  assign rd_next     = {1'b0, rd_ptr} + 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      length   <= '0;
      rd_ptr   <= '0;
      record_q <= 1'b0;
    end else begin
      record_q <= record;
      if (record) begin
        rd_ptr <= '0;  // playback restarts from the top
        if (write_en)
          length <= wr_addr + 1'b1;
        else if (record_rise)
          length <= '0;
      end else if (frame_strobe && length != '0) begin
        rd_ptr <= (rd_next == length) ? '0 : rd_next[audio_pkg::STORE_ADDR_BITS-1:0];
      end
    end
  end

  //////////////////////////////
  // memory ports
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (write_en)
      mem[wr_addr[audio_pkg::STORE_ADDR_BITS-1:0]] <= mic_sample;
    rd_data <= mem[rd_ptr];  // settles long before the next strobe
  end

  // silence while recording or with nothing stored
  assign play_sample = (record || length == '0) ? '0 : rd_data;

endmodule

`default_nettype wire

//--- logic/audio_codec_top.sv
`default_nettype none
`timescale 1ns/1ns

module audio_codec_top (
  input  wire clock,          // 12.288 MHz ac97 bit clock
  input  wire reset,
  input  wire button_up,
  input  wire button_down,
  input  wire record,
  input  wire ac97_sdata_in,
  output wire codec_reset_b,
  output wire ac97_synch,
  output wire ac97_sdata_out
);

  logic [audio_pkg::VOLUME_BITS-1:0] volume;
  logic                              frame_strobe;  // end of each frame
  audio_pkg::codec_command_t         command;
  audio_pkg::sample_t                mic_sample;    // from the codec
  audio_pkg::sample_t                play_sample;   // to the codec

  volume_control volume_ctrl (
    .clock       (clock),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  codec_command_sequencer sequencer (
    .clock        (clock),
    .reset        (reset),
    .frame_strobe (frame_strobe),
    .volume       (volume),
    .command      (command)
  );

  ac97_frame_engine engine (
    .clock          (clock),
    .reset          (reset),
    .command        (command),
    .play_sample    (play_sample),
    .mic_sample     (mic_sample),
    .frame_strobe   (frame_strobe),
    .codec_reset_b  (codec_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in)
  );

  sample_store store (
    .clock        (clock),
    .reset        (reset),
    .frame_strobe (frame_strobe),
    .record       (record),
    .mic_sample   (mic_sample),
    .play_sample  (play_sample)
  );

endmodule

`default_nettype wire

//--- bench/frame_record.svh
`ifndef FRAME_RECORD_SVH
`define FRAME_RECORD_SVH

// one decoded output frame, as seen on the serial line
typedef struct packed {
  int          index;       // frame number since codec release
  logic [8:0]  length;      // bit clocks from this synch rise to the next
  logic [8:0]  synch_high;  // bit clocks with synch high
  logic [4:0]  tags;        // slot 0 bits 0..4
  logic [10:0] tag_rest;    // slot 0 bits 5..15
  logic [19:0] slot1;
  logic [19:0] slot2;
  logic [19:0] slot3;
  logic [19:0] slot4;
  logic [7:0]  mic;         // sample sent back in slot 3 of this frame
} frame_record_t;

`endif

//--- bench/codec_model.sv
`include "frame_record.svh"
`default_nettype none
`timescale 1ns/1ns

module codec_model (
  input  wire           clock,
  input  wire           synch,
  input  wire           sdata_out,     // from the controller
  output logic          sdata_in,      // to the controller
  output frame_record_t frame,         // last finished frame
  output int            frames_seen,
  output int            position,      // bit count of the current frame
  output int            frame_number
);

  integer        seed;
  logic          synch_q;
  logic          started;
  logic [95:0]   bits;       // slots 0..4, first bit at the top
  logic [19:0]   mic_word;   // slot 3 sent this frame
  int            pos;
  int            high_count;
  int            count;
  frame_record_t rec;

  initial begin
    seed         = 32'hbefe;
    synch_q      = 1'b0;
    started      = 1'b0;
    bits         = '0;
    mic_word     = '0;
    pos          = 0;
    high_count   = 0;
    count        = 0;
    rec          = '0;
    sdata_in     = 1'b0;
    frame        = '0;
    frames_seen  = 0;
    position     = 0;
    frame_number = 0;
  end

  // everything moves on the falling edge, away from the controller's edge
  always @(negedge clock) begin
    if (synch && !synch_q) begin
      if (started) begin
        // close out the frame that just ended
        rec.index      = count;
        rec.length     = 9'(pos + 1);
        rec.synch_high = 9'(high_count);
        rec.tags       = bits[95:91];
        rec.tag_rest   = bits[90:80];
        rec.slot1      = bits[79:60];
        rec.slot2      = bits[59:40];
        rec.slot3      = bits[39:20];
        rec.slot4      = bits[19:0];
        rec.mic        = mic_word[19:12];
        frame       <= rec;
        frames_seen <= frames_seen + 1;
        count       = count + 1;
      end
      started    = 1'b1;
      pos        = 0;
      high_count = 0;
      bits       = '0;
      mic_word   = 20'($random(seed));  // fresh mic sample
    end else if (started) begin
      pos = pos + 1;
    end
    if (started) begin
      if (synch)
        high_count = high_count + 1;
      if (pos >= 1 && pos <= 96)
        bits = {bits[94:0], sdata_out};  // bit n shows at count n+1
      // left slot, msb first, sampled at counts 57..76
      sdata_in     <= (pos >= 57 && pos <= 76) ? mic_word[76 - pos] : 1'b0;
      position     <= pos;
      frame_number <= count;
    end
    synch_q = synch;
  end

endmodule

`default_nettype wire

//--- bench/audio_codec_tb.sv
`include "frame_record.svh"
`default_nettype none
`timescale 1ns/1ns

module audio_codec_tb;

  localparam int RECORD_FRAMES = 20;
  localparam int PRESS_CYCLES  = 2 * (audio_pkg::DEBOUNCE_CYCLES + 16);  // down and up
  // 15 presses, 200 frames, codec reset, plus 10%
  localparam int TIMEOUT_CYCLES = (15 * PRESS_CYCLES + 200 * audio_pkg::FRAME_BITS
                                   + audio_pkg::CODEC_RESET_CYCLES) / 10 * 11;

  logic clock;
  logic reset;
  logic button_up;
  logic button_down;
  logic record;
  wire  ac97_sdata_in;
  wire  codec_reset_b;
  wire  ac97_synch;
  wire  ac97_sdata_out;

  frame_record_t frame;
  int   frames_seen;
  int   position;
  int   frame_number;

  int   cycle_count;
  int   frames_checked;
  int   headphone_count;
  logic [19:0] last_headphone;  // slot 2 of the latest headphone write
  int   record_start;           // first recorded frame or -1
  int   release_cycles;
  logic [7:0] mic_history [$];

  audio_codec_top UUT (
    .clock          (clock),
    .reset          (reset),
    .button_up      (button_up),
    .button_down    (button_down),
    .record         (record),
    .ac97_sdata_in  (ac97_sdata_in),
    .codec_reset_b  (codec_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out)
  );

  codec_model codec (
    .clock        (clock),
    .synch        (ac97_synch),
    .sdata_out    (ac97_sdata_out),
    .sdata_in     (ac97_sdata_in),
    .frame        (frame),
    .frames_seen  (frames_seen),
    .position     (position),
    .frame_number (frame_number)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////
  // failure helpers
  //////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic mismatch(input string test, input int expected, input int actual);
    fail_now($sformatf("error %s: expected %0h, actual %0h", test, expected, actual));
  endtask

  // step table of the codec register loop
  function automatic logic [7:0] table_address(input int step);
    case (step)
      3:       return 8'h04;
      5:       return 8'h18;
      6:       return 8'h1A;
      7:       return 8'h1C;
      9:       return 8'h0E;
      10:      return 8'h0A;
      11:      return 8'h20;
      default: return 8'h80;  // read id
    endcase
  endfunction

  function automatic logic [15:0] table_data(input int step);
    case (step)
      5:       return 16'h0808;
      7:       return 16'h0F0F;
      9:       return 16'h8048;
      11:      return 16'h8000;
      default: return 16'h0000;
    endcase
  endfunction

  // synch never shows while the codec is held in reset
  hold_check: assert property (@(posedge clock) !codec_reset_b |-> !ac97_synch)
    else fail_now("synch went high while the codec was still in reset");

  //////////////////////////////
  // per frame checks
  //////////////////////////////

  task automatic check_frame(input frame_record_t rec);
    logic v;
    int   step;
    int   k;
    logic [7:0] want;
    v = (rec.index > 0);
    assert (rec.length == 9'd256) else mismatch("frame length", 256, rec.length);
    assert (rec.synch_high == 9'd16) else mismatch("synch width", 16, rec.synch_high);
    assert (rec.tags == {1'b1, v, v, 2'b11}) else mismatch("slot 0 tags", {1'b1, v, v, 2'b11},
                                                           rec.tags);
    assert (rec.tag_rest == '0) else mismatch("slot 0 spare tags", 0, rec.tag_rest);
    if (rec.index == 0) begin
      assert (rec.slot1 == '0) else mismatch("first frame slot 1", 0, rec.slot1);
      assert (rec.slot2 == '0) else mismatch("first frame slot 2", 0, rec.slot2);
    end else begin
      step = (rec.index - 1) % 16;  // one command step per frame
      assert (rec.slot1 == {table_address(step), 12'h000})
        else mismatch("command address", {table_address(step), 12'h000}, rec.slot1);
      if (step == 3) begin
        // headphone word follows the button presses
        headphone_count <= headphone_count + 1;
        last_headphone  <= rec.slot2;
      end else begin
        assert (rec.slot2 == {table_data(step), 4'h0})
          else mismatch("command data", {table_data(step), 4'h0}, rec.slot2);
      end
    end
    // playback path
    if (record_start < 0 || rec.index <= record_start + RECORD_FRAMES) begin
      want = '0;  // nothing stored yet or still recording
    end else begin
      k    = (rec.index - record_start - RECORD_FRAMES - 1) % RECORD_FRAMES;
      want = mic_history[record_start + k];
    end
    assert (rec.slot3 == {want, 12'h000}) else mismatch("slot 3 sample", want, rec.slot3);
    assert (rec.slot4 == {want, 12'h000}) else mismatch("slot 4 sample", want, rec.slot4);
    mic_history.push_back(rec.mic);
  endtask

  always @(posedge clock) begin
    if (frames_seen != frames_checked) begin
      check_frame(frame);
      frames_checked <= frames_checked + 1;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
      fail_now("timeout, the tests did not finish in time");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic wait_frames(input int n);
    while (frames_checked < n)
      @(posedge clock);
  endtask

  task automatic wait_position(input int frame_no, input int pos);
    @(posedge clock);
    while (frame_number != frame_no || position != pos)
      @(posedge clock);
    @(negedge clock);
  endtask

  task automatic press(input logic up);
    @(negedge clock);
    if (up) button_up = 1'b1;
    else button_down = 1'b1;
    repeat (audio_pkg::DEBOUNCE_CYCLES + 16) @(negedge clock);
    button_up   = 1'b0;
    button_down = 1'b0;
    repeat (audio_pkg::DEBOUNCE_CYCLES + 16) @(negedge clock);
  endtask

  task automatic wait_headphone(input string test, input int atten);
    int n;
    logic [4:0]  a;
    logic [19:0] want;
    n    = headphone_count;
    a    = 5'(atten);
    want = {3'b000, a, 3'b000, a, 4'h0};  // same attenuation in both halves
    while (headphone_count == n)
      @(posedge clock);
    assert (last_headphone == want) else mismatch(test, want, last_headphone);
  endtask

  initial begin
    reset           = 1'b1;
    button_up       = 1'b0;
    button_down     = 1'b0;
    record          = 1'b0;
    cycle_count     = 0;
    frames_checked  = 0;
    headphone_count = 0;
    last_headphone  = '0;
    record_start    = -1;
    release_cycles  = 0;

    repeat (5) @(negedge clock);
    assert (!codec_reset_b && !ac97_synch && !ac97_sdata_out)
      else mismatch("outputs in reset", 0, {codec_reset_b, ac97_synch, ac97_sdata_out});
    reset = 1'b0;

    // codec release delay
    while (!codec_reset_b) begin
      @(negedge clock);
      release_cycles++;
    end
    assert (release_cycles == audio_pkg::CODEC_RESET_CYCLES + 1)
      else mismatch("codec release", audio_pkg::CODEC_RESET_CYCLES + 1, release_cycles);

    wait_frames(20);  // full command loop plus a few
    wait_headphone("headphone at reset", 23);

    // record 20 frames then play them back in a loop
    record_start = frame_number + 2;
    wait_position(record_start, 100);
    record = 1'b1;
    wait_position(record_start + RECORD_FRAMES, 100);
    record = 1'b0;
    wait_frames(record_start + 3 * RECORD_FRAMES + 4);  // over two loops

    repeat (3) press(1'b1);
    wait_headphone("volume up", 20);
    repeat (12) press(1'b0);
    wait_headphone("volume floor", 31);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+bench
logic/audio_pkg.sv
logic/button_debounce.sv
logic/volume_control.sv
logic/codec_command_sequencer.sv
logic/ac97_frame_engine.sv
logic/sample_store.sv
logic/audio_codec_top.sv
bench/codec_model.sv
bench/audio_codec_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module audio_codec_tb -Mdir obj_dir

# the simulation stops with a nonzero status on failure, the log decides
./obj_dir/Vaudio_codec_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
